/* logic/udma_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared types for the uDMA channel core. The L2 space is 4 KiB at most,
// so addresses are 12 bits wide and sizes count bytes in 16 bits.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package udma_pkg;

    localparam int unsigned L2_AW   = 12;
    localparam int unsigned TRANS_W = 16;
    localparam int unsigned CFG_AW  = 5;

    // Register map, word index on the configuration port
    typedef enum logic [CFG_AW-1:0] {
        RX_SADDR   = 5'd0,
        RX_SIZE    = 5'd1,
        UDMA_RXCFG = 5'd2,
        TX_SADDR   = 5'd3,
        TX_SIZE    = 5'd4,
        UDMA_TXCFG = 5'd5,
        STATUS     = 5'd9
    } cfg_addr_e;

    typedef logic [L2_AW-1:0]   l2_addr_t;
    typedef logic [TRANS_W-1:0] trans_size_t;
    typedef logic [31:0]        l2_word_t;

    typedef struct packed {
        logic [25:0] rsvd_hi;
        logic        clr;                 // Abort the channel
        logic        en;                  // Kick a transfer
        logic [3:0]  rsvd_lo;
    } chan_cfg_t;

    typedef struct packed {
        logic [31-L2_AW:0] rsvd;
        l2_addr_t          addr;
    } cfg_addr_view_t;

    typedef struct packed {
        logic [31-TRANS_W:0] rsvd;
        trans_size_t         size;
    } cfg_size_view_t;

    // One write word, decoded per target register
    typedef union packed {
        chan_cfg_t      cfg;
        cfg_addr_view_t addr_v;
        cfg_size_view_t size_v;
    } cfg_word_u;

    typedef struct packed {
        logic              valid;
        logic              rwn;           // 1 = read
        logic [CFG_AW-1:0] addr;
        l2_word_t          data;
    } cfg_req_t;

    typedef struct packed {
        logic     we;
        l2_addr_t addr;
        logic [7:0] data;
    } mem_wr_t;

    typedef struct packed {
        logic        start;
        logic        clr;
        l2_addr_t    addr;
        trans_size_t size;
    } xfer_cmd_t;

    typedef struct packed {
        logic [31-16-L2_AW:0] rsvd_hi;
        l2_addr_t             rx_err_addr;  // Bits 27:16
        logic [12:0]          rsvd_lo;
        logic                 rx_error;
        logic                 rx_busy;
        logic                 tx_busy;
    } status_t;

endpackage

`default_nettype wire

/* logic/udma_cfg_decode.sv */
////////////////////////////////////////////////////////////////////////////
// Register file of the channel. Requests are single-cycle strobes with no
// handshake. Start and clear strobes come two cycles after the write.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module udma_cfg_decode (
    input  logic                   sys_clk,
    input  logic                   rst_n,
    input  udma_pkg::cfg_req_t     cfg_req_i,
    output udma_pkg::l2_word_t     cfg_data_o,
    input  logic                   tx_busy_i,
    input  logic                   rx_busy_i,
    input  logic                   rx_error_i,
    input  udma_pkg::l2_addr_t     rx_err_addr_i,
    output udma_pkg::xfer_cmd_t    tx_cmd_o,
    output udma_pkg::xfer_cmd_t    rx_cmd_o
);
    import udma_pkg::*;

    logic        wr_s;
    logic        rd_s;
    cfg_word_u   wdata;
    l2_addr_t    rx_saddr_q;
    l2_addr_t    tx_saddr_q;
    trans_size_t rx_size_q;
    trans_size_t tx_size_q;
    logic        tx_start_d, tx_clr_d, rx_start_d, rx_clr_d;
    logic        tx_start_q, tx_clr_q, rx_start_q, rx_clr_q;
    status_t     status;
    chan_cfg_t   rx_cfg_rd;
    chan_cfg_t   tx_cfg_rd;
    l2_word_t    rdata;

    assign wr_s  = cfg_req_i.valid & ~cfg_req_i.rwn;
    assign rd_s  = cfg_req_i.valid & cfg_req_i.rwn;
    assign wdata = cfg_req_i.data;

    ////////////////////////////////////////////////////////////////////////////
    // Address and size registers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_saddr_q <= '0;
            rx_size_q  <= '0;
            tx_saddr_q <= '0;
            tx_size_q  <= '0;
        end else if (wr_s) begin
            case (cfg_req_i.addr)
                RX_SADDR: rx_saddr_q <= wdata.addr_v.addr;
                RX_SIZE:  rx_size_q  <= wdata.size_v.size;
                TX_SADDR: tx_saddr_q <= wdata.addr_v.addr;
                TX_SIZE:  tx_size_q  <= wdata.size_v.size;
                default: ;                          // Unmapped or strobe-only
            endcase
        end
    end

    // First stage latches the decoded write, second stage is the strobe
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_start_d <= 1'b0;
            tx_clr_d   <= 1'b0;
            rx_start_d <= 1'b0;
            rx_clr_d   <= 1'b0;
            tx_start_q <= 1'b0;
            tx_clr_q   <= 1'b0;
            rx_start_q <= 1'b0;
            rx_clr_q   <= 1'b0;
        end else begin
            tx_start_d <= wr_s && (cfg_req_i.addr == UDMA_TXCFG) && wdata.cfg.en;
            tx_clr_d   <= wr_s && (cfg_req_i.addr == UDMA_TXCFG) && wdata.cfg.clr;
            rx_start_d <= wr_s && (cfg_req_i.addr == UDMA_RXCFG) && wdata.cfg.en;
            rx_clr_d   <= wr_s && (cfg_req_i.addr == UDMA_RXCFG) && wdata.cfg.clr;
            tx_start_q <= tx_start_d;
            tx_clr_q   <= tx_clr_d;
            rx_start_q <= rx_start_d;
            rx_clr_q   <= rx_clr_d;
        end
    end

    assign tx_cmd_o = xfer_cmd_t'{start: tx_start_q, clr: tx_clr_q,
                                  addr: tx_saddr_q, size: tx_size_q};
    assign rx_cmd_o = xfer_cmd_t'{start: rx_start_q, clr: rx_clr_q,
                                  addr: rx_saddr_q, size: rx_size_q};

    ////////////////////////////////////////////////////////////////////////////
    // Read-back
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        status             = '0;
        status.tx_busy     = tx_busy_i;
        status.rx_busy     = rx_busy_i;
        status.rx_error    = rx_error_i;
        status.rx_err_addr = rx_err_addr_i;
        rx_cfg_rd          = '0;
        rx_cfg_rd.en       = rx_busy_i;         // Enable reads as channel busy
        tx_cfg_rd          = '0;
        tx_cfg_rd.en       = tx_busy_i;
        case (cfg_req_i.addr)
            RX_SADDR:   rdata = l2_word_t'(rx_saddr_q);
            RX_SIZE:    rdata = l2_word_t'(rx_size_q);
            UDMA_RXCFG: rdata = rx_cfg_rd;
            TX_SADDR:   rdata = l2_word_t'(tx_saddr_q);
            TX_SIZE:    rdata = l2_word_t'(tx_size_q);
            UDMA_TXCFG: rdata = tx_cfg_rd;
            STATUS:     rdata = status;
            default:    rdata = '0;
        endcase
    end

    assign cfg_data_o = rd_s ? rdata : '0;

endmodule

`default_nettype wire

/* logic/udma_l2_mem.sv */
////////////////////////////////////////////////////////////////////////////
// Byte-wide L2 model with a preload port and two little-endian word reads.
// MEM_DEPTH must be a power of two from 4 to 4096. Reads wrap at the top.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module udma_l2_mem #(
    parameter int unsigned MEM_DEPTH = 4096
) (
    input  logic                 sys_clk,
    input  udma_pkg::mem_wr_t    mem_wr_i,
    input  udma_pkg::l2_addr_t   tx_addr_i,
    output udma_pkg::l2_word_t   tx_word_o,
    input  udma_pkg::l2_addr_t   rx_addr_i,
    output udma_pkg::l2_word_t   rx_word_o
);
    import udma_pkg::*;

    localparam int unsigned IDX_W = $clog2(MEM_DEPTH);

    logic [7:0] mem_q [MEM_DEPTH];

    always_ff @(posedge sys_clk) begin
        if (mem_wr_i.we) begin
            mem_q[mem_wr_i.addr[IDX_W-1:0]] <= mem_wr_i.data;
        end
    end

    // Bytes addr+3 down to addr, index arithmetic wraps at the depth
    function automatic l2_word_t rd_word(input l2_addr_t addr);
        l2_word_t         word;
        logic [IDX_W-1:0] idx;
        for (int b = 0; b < 4; b++) begin
            idx             = addr[IDX_W-1:0] + IDX_W'(b);
            word[8*b +: 8]  = mem_q[idx];
        end
        return word;
    endfunction

    always_comb begin
        tx_word_o = rd_word(tx_addr_i);         // TX streamer port
        rx_word_o = rd_word(rx_addr_i);         // RX checker port
    end

endmodule

`default_nettype wire

/* logic/udma_tx_stream.sv */
////////////////////////////////////////////////////////////////////////////
// TX streamer. Sends ceiling(size/4) words from L2 under valid/ready.
// A start while busy restarts the transfer. Clear aborts without done.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module udma_tx_stream (
    input  logic                   sys_clk,
    input  logic                   rst_n,
    input  udma_pkg::xfer_cmd_t    tx_cmd_i,
    output udma_pkg::l2_addr_t     mem_addr_o,
    input  udma_pkg::l2_word_t     mem_word_i,
    output udma_pkg::l2_word_t     tx_data_o,
    output logic                   tx_valid_o,
    input  logic                   tx_ready_i,
    output udma_pkg::trans_size_t  tx_bytes_left_o,
    output logic                   tx_busy_o,
    output logic                   tx_done_o
);
    import udma_pkg::*;

    logic               busy_q;
    logic               done_q;
    l2_addr_t           addr_q;
    trans_size_t        count_q;
    trans_size_t        size_q;
    logic               beat;
    logic [TRANS_W:0]   cnt_next;           // One extra bit for the last beat

    assign tx_valid_o = busy_q && (count_q < size_q);
    assign beat       = tx_valid_o && tx_ready_i;
    assign cnt_next   = {1'b0, count_q} + (TRANS_W+1)'(4);

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            addr_q  <= '0;
            count_q <= '0;
            size_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (tx_cmd_i.clr) begin
                busy_q <= 1'b0;
            end else if (tx_cmd_i.start) begin
                busy_q  <= 1'b1;
                addr_q  <= tx_cmd_i.addr;
                count_q <= '0;
                size_q  <= tx_cmd_i.size;       // Held against later writes
            end else if (beat) begin
                addr_q  <= addr_q + L2_AW'(4);
                count_q <= cnt_next[TRANS_W-1:0];
                if (cnt_next >= {1'b0, size_q}) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end else if (busy_q && (count_q >= size_q)) begin
                busy_q <= 1'b0;                 // Zero-size transfer
                done_q <= 1'b1;
            end
        end
    end

    assign mem_addr_o      = addr_q;
    assign tx_data_o       = mem_word_i;        // Stable while addr_q holds
    assign tx_bytes_left_o = busy_q ? (size_q - count_q) : '0;
    assign tx_busy_o       = busy_q;
    assign tx_done_o       = done_q;

endmodule

`default_nettype wire

/* logic/udma_rx_check.sv */
////////////////////////////////////////////////////////////////////////////
// RX checker. Every beat is accepted and compared against L2. Only the
// bytes still inside the transfer are compared. Beats while idle are dropped.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module udma_rx_check (
    input  logic                   sys_clk,
    input  logic                   rst_n,
    input  udma_pkg::xfer_cmd_t    rx_cmd_i,
    input  udma_pkg::l2_word_t     rx_data_i,
    input  logic                   rx_valid_i,
    output udma_pkg::l2_addr_t     mem_addr_o,
    input  udma_pkg::l2_word_t     mem_word_i,
    output logic                   rx_busy_o,
    output logic                   rx_done_o,
    output logic                   rx_error_o,
    output udma_pkg::l2_addr_t     rx_err_addr_o
);
    import udma_pkg::*;

    logic        busy_q;
    logic        done_q;
    logic        err_q;
    l2_addr_t    err_addr_q;
    l2_addr_t    ptr_q;
    trans_size_t left_q;
    logic        beat;
    logic [2:0]  take;                      // Bytes checked on this beat
    l2_word_t    mask;
    logic        mismatch;
    trans_size_t left_next;

    assign beat      = rx_valid_i && busy_q;
    assign take      = (left_q >= trans_size_t'(4)) ? 3'd4 : left_q[2:0];
    assign left_next = left_q - trans_size_t'(take);

    ////////////////////////////////////////////////////////////////////////////
    // Tail mask and compare
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            mask[8*b +: 8] = (b < int'(take)) ? 8'hFF : 8'h00;
        end
    end

    assign mismatch = |((rx_data_i ^ mem_word_i) & mask);

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            done_q     <= 1'b0;
            err_q      <= 1'b0;
            err_addr_q <= '0;
            ptr_q      <= '0;
            left_q     <= '0;
        end else begin
            done_q <= 1'b0;
            if (rx_cmd_i.clr) begin
                busy_q <= 1'b0;                 // Error state is kept
            end else if (rx_cmd_i.start) begin
                busy_q     <= 1'b1;
                ptr_q      <= rx_cmd_i.addr;
                left_q     <= rx_cmd_i.size;
                err_q      <= 1'b0;
                err_addr_q <= '0;
            end else if (beat) begin
                ptr_q  <= ptr_q + L2_AW'(4);
                left_q <= left_next;
                if (mismatch && !err_q) begin
                    err_q      <= 1'b1;
                    err_addr_q <= ptr_q;        // First bad word only
                end
                if (left_next == '0) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end else if (busy_q && (left_q == '0)) begin
                busy_q <= 1'b0;                 // Zero-size check
                done_q <= 1'b1;
            end
        end
    end

    assign mem_addr_o    = ptr_q;
    assign rx_busy_o     = busy_q;
    assign rx_done_o     = done_q;
    assign rx_error_o    = err_q;
    assign rx_err_addr_o = err_addr_q;

endmodule

`default_nettype wire

/* logic/udma_channel_top.sv */
////////////////////////////////////////////////////////////////////////////
// uDMA channel core. TX streams words out of L2, RX checks words against it.
// The RX side has no ready and takes every beat.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module udma_channel_top #(
    parameter int unsigned MEM_DEPTH = 4096
) (
    input  logic                   sys_clk,
    input  logic                   rst_n,
    input  udma_pkg::cfg_req_t     cfg_req_i,
    output udma_pkg::l2_word_t     cfg_data_o,
    input  udma_pkg::mem_wr_t      mem_wr_i,
    output udma_pkg::l2_word_t     tx_data_o,
    output logic                   tx_valid_o,
    input  logic                   tx_ready_i,
    output udma_pkg::trans_size_t  tx_bytes_left_o,
    output logic                   tx_done_o,
    input  udma_pkg::l2_word_t     rx_data_i,
    input  logic                   rx_valid_i,
    output logic                   rx_done_o,
    output logic                   rx_error_o
);
    import udma_pkg::*;

    xfer_cmd_t tx_cmd;
    xfer_cmd_t rx_cmd;
    l2_addr_t  tx_mem_addr;
    l2_word_t  tx_mem_word;
    l2_addr_t  rx_mem_addr;
    l2_word_t  rx_mem_word;
    logic      tx_busy;
    logic      rx_busy;
    l2_addr_t  rx_err_addr;

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////
    udma_cfg_decode u_cfg_decode (
        .sys_clk        (sys_clk),
        .rst_n          (rst_n),
        .cfg_req_i      (cfg_req_i),
        .cfg_data_o     (cfg_data_o),
        .tx_busy_i      (tx_busy),
        .rx_busy_i      (rx_busy),
        .rx_error_i     (rx_error_o),
        .rx_err_addr_i  (rx_err_addr),
        .tx_cmd_o       (tx_cmd),
        .rx_cmd_o       (rx_cmd)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////////////////////
    udma_l2_mem #(
        .MEM_DEPTH      (MEM_DEPTH)
    ) u_l2_mem (
        .sys_clk        (sys_clk),
        .mem_wr_i       (mem_wr_i),
        .tx_addr_i      (tx_mem_addr),
        .tx_word_o      (tx_mem_word),
        .rx_addr_i      (rx_mem_addr),
        .rx_word_o      (rx_mem_word)
    );

    udma_tx_stream u_tx_stream (
        .sys_clk         (sys_clk),
        .rst_n           (rst_n),
        .tx_cmd_i        (tx_cmd),
        .mem_addr_o      (tx_mem_addr),
        .mem_word_i      (tx_mem_word),
        .tx_data_o       (tx_data_o),
        .tx_valid_o      (tx_valid_o),
        .tx_ready_i      (tx_ready_i),
        .tx_bytes_left_o (tx_bytes_left_o),
        .tx_busy_o       (tx_busy),
        .tx_done_o       (tx_done_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Result
    ////////////////////////////////////////////////////////////////////////////
    udma_rx_check u_rx_check (
        .sys_clk        (sys_clk),
        .rst_n          (rst_n),
        .rx_cmd_i       (rx_cmd),
        .rx_data_i      (rx_data_i),
        .rx_valid_i     (rx_valid_i),
        .mem_addr_o     (rx_mem_addr),
        .mem_word_i     (rx_mem_word),
        .rx_busy_o      (rx_busy),
        .rx_done_o      (rx_done_o),
        .rx_error_o     (rx_error_o),
        .rx_err_addr_o  (rx_err_addr)
    );

endmodule

`default_nettype wire

/* sim/tb_udma_tasks.svh */
////////////////////////////////////////////////////////////////////////////
// Tasks of the channel testbench, included in its module body. Inputs
// change at the rising edge and outputs are sampled at the falling edge.
////////////////////////////////////////////////////////////////////////////
`ifndef TB_UDMA_TASKS_SVH
`define TB_UDMA_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////////////////////
task automatic check_word(input string name, input l2_word_t got, input l2_word_t exp);
    if (got !== exp) begin
        $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_size(input string name, input trans_size_t got, input trans_size_t exp);
    if (got !== exp) begin
        $display("Error: %s = 0x%04h, expected 0x%04h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_status(input string name, input status_t got, input status_t exp);
    if (got !== exp) begin
        $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
        abort_run();
    end
endtask

task automatic expect_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        abort_run();
    end
endtask

////////////////////////////////////////////////////////////////////////////
// Reference model and bus helpers
////////////////////////////////////////////////////////////////////////////
function automatic l2_word_t mirror_word(input l2_addr_t addr);
    l2_word_t word;
    l2_addr_t idx;
    for (int b = 0; b < 4; b++) begin
        idx            = addr + l2_addr_t'(b);      // Little endian, wraps at 4 KiB
        word[8*b +: 8] = mirror[idx];
    end
    return word;
endfunction

function automatic status_t expected_status(input logic tx_busy, input logic rx_busy);
    status_t st;
    st             = '0;
    st.tx_busy     = tx_busy;
    st.rx_busy     = rx_busy;
    st.rx_error    = rx_err_model;
    st.rx_err_addr = rx_err_addr_model;
    return st;
endfunction

task automatic write_reg(input logic [CFG_AW-1:0] addr, input l2_word_t data);
    @(posedge sys_clk);
    cfg_req_i <= cfg_req_t'{valid: 1'b1, rwn: 1'b0, addr: addr, data: data};
    @(posedge sys_clk);
    cfg_req_i <= '0;
endtask

task automatic read_reg(input logic [CFG_AW-1:0] addr, output l2_word_t data);
    @(posedge sys_clk);
    cfg_req_i <= cfg_req_t'{valid: 1'b1, rwn: 1'b1, addr: addr, data: '0};
    @(negedge sys_clk);
    data = cfg_data_o;                               // Combinational read-back
    @(posedge sys_clk);
    cfg_req_i <= '0;
endtask

task automatic read_expect(input logic [CFG_AW-1:0] addr, input string name,
                           input l2_word_t exp);
    l2_word_t rd;
    read_reg(addr, rd);
    check_word(name, rd, exp);
endtask

task automatic preload_mem();
    logic [31:0] rnd;
    logic [7:0]  val;
    l2_addr_t    addr;
    for (int a = 0; a < PRELOAD_BYTES; a++) begin
        addr         = l2_addr_t'(a);
        rnd          = $random(seed);
        val          = rnd[7:0] ^ addr[7:0] ^ {4'h0, addr[11:8]};
        mirror[addr] = val;
        @(posedge sys_clk);
        mem_wr_i <= mem_wr_t'{we: 1'b1, addr: addr, data: val};
    end
    @(posedge sys_clk);
    mem_wr_i <= '0;
endtask

// Streams one TX transfer, checking every accepted word and the count
task automatic run_tx(input l2_addr_t saddr, input trans_size_t size, input logic rand_ready);
    logic [31:0] rnd;
    int          beats;
    beats = 0;
    write_reg(TX_SADDR, l2_word_t'(saddr));
    write_reg(TX_SIZE, l2_word_t'(size));
    write_reg(UDMA_TXCFG, 32'h0000_0010);
    do begin
        @(posedge sys_clk);
        rnd = $random(seed);
        tx_ready_i <= rand_ready ? rnd[0] : 1'b1;
        @(negedge sys_clk);
        if (tx_valid_o) begin
            check_size("tx_bytes_left_o", tx_bytes_left_o, trans_size_t'(size - 4*beats));
        end
        if (tx_valid_o && tx_ready_i) begin
            check_word("tx_data_o", tx_data_o, mirror_word(l2_addr_t'(saddr + 4*beats)));
            beats++;
        end
    end while (!tx_done_o);
    check_size("tx beat count", trans_size_t'(beats), trans_size_t'((size + 3) / 4));
    repeat (3) begin
        @(negedge sys_clk);
        expect_flag("tx_done_o", tx_done_o, 1'b0);   // Single pulse only
        expect_flag("tx_valid_o", tx_valid_o, 1'b0);
    end
endtask

// Feeds the mirror words of one RX transfer, one of them corrupted by bad_mask
task automatic run_rx(input l2_addr_t saddr, input trans_size_t size, input int bad_idx,
                      input l2_word_t bad_mask, input logic exp_err);
    l2_word_t rd;
    l2_word_t word;
    status_t  st;
    int       n_words;
    n_words = (size + 3) / 4;
    write_reg(RX_SADDR, l2_word_t'(saddr));
    write_reg(RX_SIZE, l2_word_t'(size));
    write_reg(UDMA_RXCFG, 32'h0000_0010);
    do begin
        read_reg(STATUS, rd);
        st = status_t'(rd);
    end while (!st.rx_busy);                         // Idle beats would be dropped
    for (int i = 0; i < n_words; i++) begin
        word = mirror_word(l2_addr_t'(saddr + 4*i));
        if (i == bad_idx) begin
            word = word ^ bad_mask;
        end
        @(posedge sys_clk);
        rx_valid_i <= 1'b1;
        rx_data_i  <= word;
    end
    @(posedge sys_clk);
    rx_valid_i <= 1'b0;
    do @(negedge sys_clk); while (!rx_done_o);
    rx_err_model      = exp_err;
    rx_err_addr_model = exp_err ? l2_addr_t'(saddr + 4*bad_idx) : '0;
    expect_flag("rx_error_o", rx_error_o, exp_err);
    read_reg(STATUS, rd);
    check_status("STATUS", status_t'(rd), expected_status(1'b0, 1'b0));
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////
task automatic reset_readback();
    l2_word_t rd;
    expect_flag("tx_valid_o", tx_valid_o, 1'b0);
    expect_flag("tx_done_o", tx_done_o, 1'b0);
    expect_flag("rx_done_o", rx_done_o, 1'b0);
    expect_flag("rx_error_o", rx_error_o, 1'b0);
    read_expect(RX_SADDR, "RX_SADDR", '0);
    read_expect(RX_SIZE, "RX_SIZE", '0);
    read_expect(UDMA_RXCFG, "UDMA_RXCFG", '0);
    read_expect(TX_SADDR, "TX_SADDR", '0);
    read_expect(TX_SIZE, "TX_SIZE", '0);
    read_expect(UDMA_TXCFG, "UDMA_TXCFG", '0);
    read_reg(STATUS, rd);
    check_status("STATUS", status_t'(rd), '0);
    write_reg(RX_SADDR, 32'hA5A5_5ABC);              // Upper bits fall outside the field
    write_reg(RX_SIZE, 32'h1234_0ABC);
    write_reg(TX_SADDR, 32'h0000_0123);
    write_reg(TX_SIZE, 32'hFFFF_BEEF);
    write_reg(5'd7, 32'hDEAD_BEEF);
    read_expect(RX_SADDR, "RX_SADDR", 32'h0000_0ABC);
    read_expect(RX_SIZE, "RX_SIZE", 32'h0000_0ABC);
    read_expect(TX_SADDR, "TX_SADDR", 32'h0000_0123);
    read_expect(TX_SIZE, "TX_SIZE", 32'h0000_BEEF);
    read_expect(5'd7, "unmapped 0x07", '0);
    read_expect(5'd31, "unmapped 0x1f", '0);
endtask

task automatic tx_stream_basic();
    run_tx(12'h020, 16'd16, 1'b0);
endtask

task automatic tx_backpressure();
    run_tx(12'h040, 16'd10, 1'b1);
endtask

task automatic rx_match();
    run_rx(12'h0A0, 16'd12, 0, 32'h0000_0000, 1'b0);
endtask

task automatic rx_tail_mask();
    run_rx(12'h060, 16'd6, 1, 32'hFFFF_0000, 1'b0);  // Bad bytes lie past the end
    run_rx(12'h080, 16'd8, 0, 32'h0000_FF00, 1'b1);
endtask

task automatic tx_clear_abort();
    l2_word_t rd;
    @(posedge sys_clk);
    tx_ready_i <= 1'b0;
    write_reg(TX_SADDR, 32'h0000_0000);
    write_reg(TX_SIZE, 32'h0000_0100);
    write_reg(UDMA_TXCFG, 32'h0000_0010);
    do @(negedge sys_clk); while (!tx_valid_o);
    check_size("tx_bytes_left_o", tx_bytes_left_o, 16'h0100);
    write_reg(UDMA_TXCFG, 32'h0000_0020);
    do @(negedge sys_clk); while (tx_valid_o);
    check_size("tx_bytes_left_o", tx_bytes_left_o, '0);
    read_reg(STATUS, rd);
    check_status("STATUS", status_t'(rd), expected_status(1'b0, 1'b0));
    @(posedge sys_clk);
    tx_ready_i <= 1'b1;
endtask

`endif

/* sim/tb_udma_channel.sv */
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the uDMA channel core. Only the low PRELOAD_BYTES
// of L2 are loaded, so every transfer in the tests stays inside them.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_udma_channel;
    import udma_pkg::*;

    localparam int unsigned MEM_DEPTH     = 4096;
    localparam int unsigned PRELOAD_BYTES = 256;
    localparam int unsigned MAX_CYCLES    = 4000;   // Well above the full run

    logic        sys_clk = 1'b0;
    logic        rst_n;
    cfg_req_t    cfg_req_i;
    l2_word_t    cfg_data_o;
    mem_wr_t     mem_wr_i;
    l2_word_t    tx_data_o;
    logic        tx_valid_o;
    logic        tx_ready_i;
    trans_size_t tx_bytes_left_o;
    logic        tx_done_o;
    l2_word_t    rx_data_i;
    logic        rx_valid_i;
    logic        rx_done_o;
    logic        rx_error_o;

    logic [7:0]  mirror [MEM_DEPTH];                // Expected L2 contents
    integer      seed;
    int unsigned cycle_cnt = 0;
    logic        rx_err_model;                      // Sticky RX error seen by STATUS
    l2_addr_t    rx_err_addr_model;

    always #10 sys_clk = ~sys_clk;                  // 20 ns period

    udma_channel_top #(
        .MEM_DEPTH       (MEM_DEPTH)
    ) u_udma_channel_top (
        .sys_clk         (sys_clk),
        .rst_n           (rst_n),
        .cfg_req_i       (cfg_req_i),
        .cfg_data_o      (cfg_data_o),
        .mem_wr_i        (mem_wr_i),
        .tx_data_o       (tx_data_o),
        .tx_valid_o      (tx_valid_o),
        .tx_ready_i      (tx_ready_i),
        .tx_bytes_left_o (tx_bytes_left_o),
        .tx_done_o       (tx_done_o),
        .rx_data_i       (rx_data_i),
        .rx_valid_i      (rx_valid_i),
        .rx_done_o       (rx_done_o),
        .rx_error_o      (rx_error_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////////////////////
    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    `include "tb_udma_tasks.svh"

    initial begin
        seed              = 6;
        rx_err_model      = 1'b0;
        rx_err_addr_model = '0;
        rst_n             = 1'b0;
        cfg_req_i         = '0;
        mem_wr_i          = '0;
        tx_ready_i        = 1'b0;
        rx_data_i         = '0;
        rx_valid_i        = 1'b0;
        repeat (3) @(posedge sys_clk);
        rst_n <= 1'b1;

        reset_readback();
        preload_mem();
        tx_stream_basic();
        tx_backpressure();
        rx_match();
        rx_tail_mask();
        tx_clear_abort();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+sim
logic/udma_pkg.sv
logic/udma_cfg_decode.sv
logic/udma_l2_mem.sv
logic/udma_tx_stream.sv
logic/udma_rx_check.sv
logic/udma_channel_top.sv
sim/tb_udma_channel.sv

/* Bender.yml */
package:
  name: udma_channel

sources:
  - logic/udma_pkg.sv
  - logic/udma_cfg_decode.sv
  - logic/udma_l2_mem.sv
  - logic/udma_tx_stream.sv
  - logic/udma_rx_check.sv
  - logic/udma_channel_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_udma_channel.sv
